// ==== logic/scope_pkg.sv ====
`default_nettype none

// shared definitions for the scope acquisition core
package scope_pkg;

   // adc resolution
   localparam int sample_w = 12;

   // trigger capture states
   typedef enum logic [1:0] {
      // need a sample below the level first
      st_wait_below,
      // below seen, waiting for a rising crossing
      st_armed,
      // storing the frame into the buffer
      st_capture,
      // frame complete, buffer owned by the assembler
      st_hold
   } capture_state_t;

   // opcode carried with every output word
   typedef enum logic [1:0] {
      // one sample of the frame
      kind_sample,
      // frame minimum
      kind_min,
      // frame maximum
      kind_max,
      // frame mean, also marks end of frame
      kind_mean
   } word_kind_t;

   // order on the output is fixed
   // frame_len samples, then min, max, mean
   // the mean word closes the frame for the consumer

endpackage

`default_nettype wire

// ==== logic/sample_pacer.sv ====
`default_nettype none

// adc sample-rate pacer
// one strobe every counter_max + 1 cycles
module sample_pacer import scope_pkg::*; (
   input  logic                clk,
   input  logic                reset,
   input  logic [11:0]         counter_max,
   input  logic [sample_w-1:0] adc_data,
   output logic                adc_strobe,
   output logic                sample_valid,
   output logic [sample_w-1:0] sample_data
);

   // free running cycle counter
   logic [11:0] cycle_cnt;
   // period in use, reloaded only at wrap
   logic [11:0] cur_max;
   logic        wrap;

   assign wrap = (cycle_cnt == cur_max);

   // rate counter and strobe
   always_ff @(posedge clk) begin
      if (reset) begin
         cycle_cnt  <= '0;
         cur_max    <= counter_max;
         adc_strobe <= 1'b0;
      end else begin
         // strobe lands one cycle after the wrap
         adc_strobe <= wrap;
         if (wrap) begin
            cycle_cnt <= '0;
            // new rate only from here on
            cur_max   <= counter_max;
         end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
         end
      end
   end

   // valid pulse trails the strobe edge by one cycle
   always_ff @(posedge clk) begin
      if (reset) begin
         sample_valid <= 1'b0;
      end else begin
         sample_valid <= adc_strobe;
      end
   end

   // adc data taken on the strobe edge
   // adc model steps on this same edge
   always_ff @(posedge clk) begin
      if (adc_strobe) begin
         sample_data <= adc_data;
      end
   end

endmodule

`default_nettype wire

// ==== logic/trigger_capture.sv ====
`default_nettype none

// rising-edge trigger and frame buffer
// buffer is held until the assembler releases it
module trigger_capture import scope_pkg::*; #(
   parameter int frame_len = 64
) (
   input  logic                         clk,
   input  logic                         reset,
   input  logic [sample_w-1:0]          trigger_level,
   input  logic                         sample_valid,
   input  logic [sample_w-1:0]          sample_data,
   input  logic                         frame_release,
   input  logic [$clog2(frame_len)-1:0] rd_addr,
   output logic                         frame_start,
   output logic                         frame_done,
   output logic [sample_w-1:0]          rd_data
);

   localparam int addr_w = $clog2(frame_len);

   capture_state_t state;

   // last accepted sample, for crossing detect
   logic [sample_w-1:0] prev_sample;
   // next buffer slot, wraps to zero after the last
   logic [addr_w-1:0]   wr_addr;
   logic                last_slot;
   logic                crossing;
   logic                wr_en;

   // frame storage
   logic [sample_w-1:0] buffer [frame_len];

   // at or above the level, previous one below
   assign crossing = (sample_data >= trigger_level) && (prev_sample < trigger_level);

   // trigger sample itself starts the frame
   assign frame_start = sample_valid && (state == st_armed) && crossing;

   // trigger sample goes to slot 0, the rest follow
   assign wr_en = frame_start || (sample_valid && (state == st_capture));

   assign last_slot = (wr_addr == addr_w'(frame_len - 1));

   // capture fsm
   always_ff @(posedge clk) begin
      if (reset) begin
         state      <= st_wait_below;
         wr_addr    <= '0;
         frame_done <= 1'b0;
      end else begin
         frame_done <= 1'b0;
         case (state)
            st_wait_below: begin
               // re-arm only after a below-level sample
               if (sample_valid && (sample_data < trigger_level)) begin
                  state <= st_armed;
               end
            end
            st_armed: begin
               if (frame_start) begin
                  state <= st_capture;
               end
            end
            st_capture: begin
               if (sample_valid && last_slot) begin
                  state      <= st_hold;
                  // pulse in the cycle after the last store
                  frame_done <= 1'b1;
               end
            end
            st_hold: begin
               // samples arriving here are dropped
               if (frame_release) begin
                  state <= st_wait_below;
               end
            end
            default: begin
               state <= st_wait_below;
            end
         endcase
         if (wr_en) begin
            wr_addr <= wr_addr + 1'b1;
         end
      end
   end

   // previous sample tracking
   // hold samples are not accepted
   always_ff @(posedge clk) begin
      if (sample_valid && (state != st_hold)) begin
         prev_sample <= sample_data;
      end
   end

   // buffer write port
   always_ff @(posedge clk) begin
      if (wr_en) begin
         buffer[wr_addr] <= sample_data;
      end
   end

   // registered read port, one cycle latency
   always_ff @(posedge clk) begin
      rd_data <= buffer[rd_addr];
   end

endmodule

`default_nettype wire

// ==== logic/signal_stats.sv ====
`default_nettype none

// min, max and mean over one triggered frame
// mean is sum >> log2(frame_len), truncated
module signal_stats import scope_pkg::*; #(
   parameter int frame_len = 64
) (
   input  logic                clk,
   input  logic                reset,
   input  logic                sample_valid,
   input  logic [sample_w-1:0] sample_data,
   input  logic                frame_start,
   output logic                stats_done,
   output logic [sample_w-1:0] stat_min,
   output logic [sample_w-1:0] stat_max,
   output logic [sample_w-1:0] stat_mean
);

   localparam int addr_w = $clog2(frame_len);
   // sum of frame_len samples cannot overflow this
   localparam int sum_w  = sample_w + addr_w;

   logic                running;
   logic [addr_w-1:0]   count;
   logic                last;
   logic [sample_w-1:0] acc_min;
   logic [sample_w-1:0] acc_max;
   logic [sum_w-1:0]    acc_sum;
   logic [sample_w-1:0] min_next;
   logic [sample_w-1:0] max_next;
   logic [sum_w-1:0]    sum_next;

   // accumulators with the current sample folded in
   assign min_next = (sample_data < acc_min) ? sample_data : acc_min;
   assign max_next = (sample_data > acc_max) ? sample_data : acc_max;
   assign sum_next = acc_sum + sum_w'(sample_data);

   assign last = (count == addr_w'(frame_len - 1));

   // frame sample counter
   always_ff @(posedge clk) begin
      if (reset) begin
         running    <= 1'b0;
         count      <= '0;
         stats_done <= 1'b0;
      end else begin
         stats_done <= 1'b0;
         if (sample_valid && frame_start) begin
            running <= 1'b1;
            count   <= addr_w'(1);
         end else if (sample_valid && running) begin
            count <= count + 1'b1;
            if (last) begin
               running <= 1'b0;
               // lines up with frame_done
               stats_done <= 1'b1;
            end
         end
      end
   end

   // accumulators and published results
   always_ff @(posedge clk) begin
      if (sample_valid && frame_start) begin
         // trigger sample seeds everything
         acc_min <= sample_data;
         acc_max <= sample_data;
         acc_sum <= sum_w'(sample_data);
      end else if (sample_valid && running) begin
         acc_min <= min_next;
         acc_max <= max_next;
         acc_sum <= sum_next;
         if (last) begin
            stat_min  <= min_next;
            stat_max  <= max_next;
            stat_mean <= sum_next[sum_w-1:addr_w];
         end
      end
   end

endmodule

`default_nettype wire

// ==== logic/frame_assembler.sv ====
`default_nettype none

// frame + stats to display stream, credit flow control
module frame_assembler import scope_pkg::*; #(
   parameter int frame_len = 64,
   parameter int credits   = 4
) (
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         frame_done,
   input  logic                         stats_done,
   input  logic [sample_w-1:0]          stat_min,
   input  logic [sample_w-1:0]          stat_max,
   input  logic [sample_w-1:0]          stat_mean,
   input  logic [sample_w-1:0]          rd_data,
   input  logic                         out_credit,
   output logic [$clog2(frame_len)-1:0] rd_addr,
   output logic                         frame_release,
   output logic                         out_valid,
   output word_kind_t                   out_kind,
   output logic [sample_w-1:0]          out_data
);

   localparam int addr_w = $clog2(frame_len);
   localparam int cnt_w  = $clog2(credits + 1);

   logic                got_frame;
   logic                got_stats;
   logic                busy;
   logic                start;
   word_kind_t          phase;
   // next buffer address to issue
   logic [addr_w-1:0]   idx;
   logic                issue_done;
   // rd_data holds buffer[idx - 1]
   logic                pipe_valid;
   logic [cnt_w-1:0]    credit_cnt;
   logic                have_credit;
   logic                stall;
   logic                issue;
   logic                sample_word;
   logic                stat_word;
   // stats from signal_stats, and the copy used while sending
   logic [sample_w-1:0] pend_min;
   logic [sample_w-1:0] pend_max;
   logic [sample_w-1:0] pend_mean;
   logic [sample_w-1:0] frm_min;
   logic [sample_w-1:0] frm_max;
   logic [sample_w-1:0] frm_mean;

   assign start       = got_frame && got_stats && !busy;
   assign have_credit = (credit_cnt != '0);
   assign sample_word = busy && (phase == kind_sample) && pipe_valid;
   assign stat_word   = busy && (phase != kind_sample);
   assign out_valid   = (sample_word || stat_word) && have_credit;

   // no credit, hold the word sitting in the read stage
   assign stall = pipe_valid && !have_credit;
   assign issue = !stall && (start || (busy && (phase == kind_sample) && !issue_done));

   // re-present the held address so rd_data stays put
   assign rd_addr  = stall ? idx - 1'b1 : idx;
   assign out_kind = phase;

   always_comb begin
      case (phase)
         kind_min:  out_data = frm_min;
         kind_max:  out_data = frm_max;
         kind_mean: out_data = frm_mean;
         default:   out_data = rd_data;
      endcase
   end

   // sequencing and credit count
   always_ff @(posedge clk) begin
      if (reset) begin
         got_frame     <= 1'b0;
         got_stats     <= 1'b0;
         busy          <= 1'b0;
         phase         <= kind_sample;
         idx           <= '0;
         issue_done    <= 1'b0;
         pipe_valid    <= 1'b0;
         credit_cnt    <= cnt_w'(credits);
         frame_release <= 1'b0;
      end else begin
         frame_release <= 1'b0;
         // one spent per word, one back per credit pulse
         credit_cnt <= credit_cnt + cnt_w'(out_credit) - cnt_w'(out_valid);
         if (frame_done) begin
            got_frame <= 1'b1;
         end else if (start) begin
            got_frame <= 1'b0;
         end
         if (stats_done) begin
            got_stats <= 1'b1;
         end else if (start) begin
            got_stats <= 1'b0;
         end
         if (start) begin
            busy <= 1'b1;
         end
         // read stage moves unless stalled
         if (!stall) begin
            pipe_valid <= issue;
            if (issue) begin
               idx <= idx + 1'b1;
               if (idx == addr_w'(frame_len - 1)) begin
                  issue_done <= 1'b1;
               end
            end
         end
         if (out_valid) begin
            case (phase)
               kind_sample: begin
                  // last sample out, buffer goes back
                  if (issue_done) begin
                     phase         <= kind_min;
                     frame_release <= 1'b1;
                  end
               end
               kind_min: phase <= kind_max;
               kind_max: phase <= kind_mean;
               default: begin
                  phase      <= kind_sample;
                  busy       <= 1'b0;
                  issue_done <= 1'b0;
               end
            endcase
         end
      end
   end

   // stats latch, copied at frame start
   // next frame may finish before the mean word leaves
   always_ff @(posedge clk) begin
      if (stats_done) begin
         pend_min  <= stat_min;
         pend_max  <= stat_max;
         pend_mean <= stat_mean;
      end
      if (start) begin
         frm_min  <= pend_min;
         frm_max  <= pend_max;
         frm_mean <= pend_mean;
      end
   end

endmodule

`default_nettype wire

// ==== logic/scope_acquire_top.sv ====
`default_nettype none

// scope acquisition core
// pacer -> trigger capture + stats -> assembler
module scope_acquire_top import scope_pkg::*; #(
   parameter int frame_len = 64,
   parameter int credits   = 4
) (
   input  logic                clk,
   input  logic                reset,
   input  logic [sample_w-1:0] adc_data,
   input  logic [11:0]         counter_max,
   input  logic [sample_w-1:0] trigger_level,
   input  logic                out_credit,
   output logic                adc_strobe,
   output logic                out_valid,
   output word_kind_t          out_kind,
   output logic [sample_w-1:0] out_data
);

   localparam int addr_w = $clog2(frame_len);

   // paced sample stream
   logic                sample_valid;
   logic [sample_w-1:0] sample_data;
   // capture handshake
   logic                frame_start;
   logic                frame_done;
   logic                frame_release;
   logic [addr_w-1:0]   rd_addr;
   logic [sample_w-1:0] rd_data;
   // statistics
   logic                stats_done;
   logic [sample_w-1:0] stat_min;
   logic [sample_w-1:0] stat_max;
   logic [sample_w-1:0] stat_mean;

   sample_pacer u_sample_pacer (
      .clk,
      .reset,
      .counter_max,
      .adc_data,
      .adc_strobe,
      .sample_valid,
      .sample_data
   );

   trigger_capture #(
      .frame_len(frame_len)
   ) u_trigger_capture (
      .clk,
      .reset,
      .trigger_level,
      .sample_valid,
      .sample_data,
      .frame_release,
      .rd_addr,
      .frame_start,
      .frame_done,
      .rd_data
   );

   signal_stats #(
      .frame_len(frame_len)
   ) u_signal_stats (
      .clk,
      .reset,
      .sample_valid,
      .sample_data,
      .frame_start,
      .stats_done,
      .stat_min,
      .stat_max,
      .stat_mean
   );

   frame_assembler #(
      .frame_len(frame_len),
      .credits(credits)
   ) u_frame_assembler (
      .clk,
      .reset,
      .frame_done,
      .stats_done,
      .stat_min,
      .stat_max,
      .stat_mean,
      .rd_data,
      .out_credit,
      .rd_addr,
      .frame_release,
      .out_valid,
      .out_kind,
      .out_data
   );

endmodule

`default_nettype wire

// ==== test/scope_checker.sv ====
`default_nettype none

// protocol checks on the assembler credits and the pacer strobe
module scope_checker #(
   parameter int credits = 4
) (
   input logic                         clk,
   input logic                         reset,
   input logic                         out_valid,
   input logic [1:0]                   out_kind,
   input logic [$clog2(credits+1)-1:0] credit_cnt,
   input logic                         adc_strobe,
   input logic [11:0]                  counter_max
);

   // assertion failures so far, the testbench reads this at the end
   int fail_count = 0;

   // no word goes out on an empty credit count
   no_send_without_credit: assert property (
      @(posedge clk) disable iff (reset) out_valid |-> (credit_cnt != '0)
   ) else begin
      $error("word sent with zero credits");
      fail_count++;
   end

   // count never climbs above the initial pool
   credit_bounded: assert property (
      @(posedge clk) disable iff (reset) credit_cnt <= credits
   ) else begin
      $error("credit count above its maximum");
      fail_count++;
   end

   // opcode must be driven with every word
   kind_known: assert property (
      @(posedge clk) disable iff (reset) out_valid |-> !$isunknown(out_kind)
   ) else begin
      $error("out_kind unknown while out_valid is high");
      fail_count++;
   end

   // strobe lasts one cycle unless the pacer runs at full rate
   strobe_single: assert property (
      @(posedge clk) disable iff (reset) (adc_strobe && (counter_max != '0)) |=> !adc_strobe
   ) else begin
      $error("adc_strobe longer than one cycle");
      fail_count++;
   end

endmodule

// placed in the top so one instance sees the assembler and the pacer
bind scope_acquire_top scope_checker #(
   .credits(credits)
) u_checker (
   .clk        (clk),
   .reset      (reset),
   .out_valid  (out_valid),
   .out_kind   (out_kind),
   .credit_cnt (u_frame_assembler.credit_cnt),
   .adc_strobe (adc_strobe),
   .counter_max(counter_max)
);

`default_nettype wire

// ==== test/scope_tb.sv ====
`default_nettype none

// testbench for the scope acquisition core
// sawtooth adc, credit returning consumer, frame reference model
module scope_tb import scope_pkg::*; ();

   localparam int frame_len = 16;
   localparam int credits   = 4;
   // consumer behaviour
   localparam int credit_random   = 0;
   localparam int credit_withhold = 1;
   localparam int credit_fast     = 2;

   logic                clk           = 1'b0;
   logic                reset         = 1'b1;
   logic [sample_w-1:0] adc_data      = '0;
   logic [11:0]         counter_max   = 12'd3;
   logic [sample_w-1:0] trigger_level = 12'h800;
   logic                out_credit    = 1'b0;
   logic                adc_strobe;
   logic                out_valid;
   word_kind_t          out_kind;
   logic [sample_w-1:0] out_data;

   int          cyc = 0;
   int unsigned seed_ret;
   // every sample the pacer took and the cycle it was taken in
   logic [sample_w-1:0] rec_data [$];
   int                  rec_cyc [$];
   // expected words of the frame on the output
   logic [sample_w-1:0] exp_words [frame_len+3];
   word_kind_t          exp_kinds [frame_len+3];
   int          word_idx = 0;
   int          frames_done = 0;
   // first cycle whose sample can re-arm the trigger
   int          elig_cyc = 0;
   int          from_idx;
   int          trig_idx;
   // consumer bookkeeping
   int          sent_total = 0;
   int          returned_total = 0;
   int          held = 0;
   int          credit_delay = 0;
   int          credit_mode = credit_random;
   int          sent_before;
   // strobe spacing model
   int          since_reset = 0;
   int          last_strobe = -1;
   int          exp_gap = 0;
   logic [11:0] seen_cm = 12'd3;

   scope_acquire_top #(
      .frame_len(frame_len),
      .credits  (credits)
   ) i_dut (
      .clk          (clk),
      .reset        (reset),
      .adc_data     (adc_data),
      .counter_max  (counter_max),
      .trigger_level(trigger_level),
      .out_credit   (out_credit),
      .adc_strobe   (adc_strobe),
      .out_valid    (out_valid),
      .out_kind     (out_kind),
      .out_data     (out_data)
   );

   always #50 clk = ~clk;

   always @(posedge clk) begin
      cyc <= cyc + 1;
   end

   task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      if (actual !== expected) begin
         $display("** Error at time %0t: %s, got %0h, expected %0h",
                  $time, what, actual, expected);
         $display("Regression failed");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic abort_run(input string reason);
      $display("run stopped: %s", reason);
      $display("Regression failed");
      $fatal(1, "run stopped");
   endtask

   // frame = first sample at or above level after a below sample at or past from
   // returns the trigger index or -1 when the record is too short
   function automatic int build_expected(input int from, input int len,
                                         input logic [sample_w-1:0] level);
      int below;
      int trig;
      int i;
      int sum;
      logic [sample_w-1:0] lo;
      logic [sample_w-1:0] hi;
      below = -1;
      trig  = -1;
      for (i = from; i < rec_data.size() && below < 0; i++) begin
         if (rec_data[i] < level) below = i;
      end
      if (below < 0) return -1;
      for (i = below + 1; i < rec_data.size() && trig < 0; i++) begin
         if (rec_data[i] >= level) trig = i;
      end
      if (trig < 0 || trig + len > rec_data.size()) return -1;
      lo  = rec_data[trig];
      hi  = rec_data[trig];
      sum = 0;
      for (i = 0; i < len; i++) begin
         exp_words[i] = rec_data[trig + i];
         exp_kinds[i] = kind_sample;
         if (rec_data[trig + i] < lo) lo = rec_data[trig + i];
         if (rec_data[trig + i] > hi) hi = rec_data[trig + i];
         sum = sum + int'(rec_data[trig + i]);
      end
      exp_words[len]     = lo;
      exp_kinds[len]     = kind_min;
      exp_words[len + 1] = hi;
      exp_kinds[len + 1] = kind_max;
      // mean truncates
      exp_words[len + 2] = sample_w'(sum / len);
      exp_kinds[len + 2] = kind_mean;
      return trig;
   endfunction

   // sawtooth adc model with a random step
   // steps on the strobe edge
   always @(posedge clk) begin
      if (!reset && adc_strobe) begin
         rec_data.push_back(adc_data);
         rec_cyc.push_back(cyc);
         adc_data <= adc_data + sample_w'($urandom_range(320, 96));
      end
   end

   // reset levels and strobe spacing
   always @(posedge clk) begin
      if (reset) begin
         // outputs only known once the first reset edge has passed
         if (cyc > 0) begin
            check_equal(out_valid, 1'b0, "out_valid during reset");
            check_equal(adc_strobe, 1'b0, "adc_strobe during reset");
         end
         since_reset = 0;
         last_strobe = -1;
      end else begin
         if (since_reset < 2) begin
            check_equal(out_valid, 1'b0, "out_valid after reset");
            check_equal(adc_strobe, 1'b0, "adc_strobe after reset");
         end
         since_reset++;
         if (adc_strobe) begin
            if (last_strobe >= 0) check_equal(cyc - last_strobe, exp_gap, "strobe spacing");
            last_strobe = cyc;
            // rate loaded at the wrap one cycle before this strobe
            exp_gap = int'(seen_cm) + 1;
         end
      end
      seen_cm = counter_max;
   end

   // consumer returns one credit per word after a delay
   always @(posedge clk) begin
      if (!reset) begin
         if (out_valid) begin
            sent_total++;
            held++;
            check_equal(sent_total - returned_total <= credits, 1'b1, "words beyond credits");
         end
         if (out_credit) returned_total++;
         out_credit <= 1'b0;
         if (credit_delay > 0) begin
            credit_delay--;
         end else if (held > 0 && credit_mode != credit_withhold) begin
            out_credit <= 1'b1;
            held--;
            credit_delay = (credit_mode == credit_fast) ? 0 : $urandom_range(6, 0);
         end
      end
   end

   // compare output words against the reference frame
   always @(posedge clk) begin
      if (!reset && out_valid) begin
         if (word_idx == 0) begin
            from_idx = 0;
            while (from_idx < rec_data.size() && rec_cyc[from_idx] < elig_cyc) from_idx++;
            trig_idx = build_expected(from_idx, frame_len, trigger_level);
            if (trig_idx < 0) abort_run("frame sent with no crossing in the recorded samples");
         end
         check_equal(out_kind, exp_kinds[word_idx], "word kind");
         check_equal(out_data, exp_words[word_idx], "word data");
         // release follows the last sample word and re-arms two cycles later
         if (word_idx == frame_len - 1) elig_cyc = cyc + 1;
         if (word_idx == frame_len + 2) begin
            word_idx = 0;
            frames_done++;
         end else begin
            word_idx++;
         end
      end
   end

   task automatic wait_for_frames(input int target, input int limit);
      int n;
      n = 0;
      while (frames_done < target && n < limit) begin
         @(posedge clk);
         n++;
      end
      if (frames_done < target) abort_run("timed out waiting for output frames");
   endtask

   // a credit pulse still on the wire is not spent yet
   task automatic wait_for_stall(input int limit);
      int n;
      n = 0;
      @(posedge clk);
      while ((sent_total - returned_total < credits || out_credit) && n < limit) begin
         @(posedge clk);
         n++;
      end
      if (sent_total - returned_total < credits || out_credit) begin
         abort_run("assembler never used all credits");
      end
   endtask

   initial begin
      seed_ret = $urandom(32'h4e12_a608);
      repeat (8) @(posedge clk);
      reset <= 1'b0;
      @(posedge clk);
      check_equal(i_dut.u_trigger_capture.state, st_wait_below, "capture state after reset");
      check_equal(i_dut.u_frame_assembler.credit_cnt, credits, "credit count after reset");
      wait_for_frames(3, 20000);
      // consumer stops returning credits
      credit_mode = credit_withhold;
      wait_for_stall(20000);
      sent_before = sent_total;
      repeat (300) @(posedge clk);
      check_equal(sent_total, sent_before, "words sent while credits withheld");
      credit_mode = credit_random;
      wait_for_frames(5, 20000);
      credit_mode = credit_fast;
      wait_for_frames(8, 20000);
      // slower sample rate from the next wrap on
      counter_max <= 12'd6;
      credit_mode = credit_random;
      wait_for_frames(11, 30000);
      if (i_dut.u_checker.fail_count == 0) begin
         $display("Regression passed");
         $finish;
      end else begin
         $display("checker assertions failed %0d times", i_dut.u_checker.fail_count);
         $display("Regression failed");
         $fatal(1, "assertion failures");
      end
   end

endmodule

`default_nettype wire

// ==== list.f ====
logic/scope_pkg.sv
logic/sample_pacer.sv
logic/trigger_capture.sv
logic/signal_stats.sv
logic/frame_assembler.sv
logic/scope_acquire_top.sv
test/scope_checker.sv
test/scope_tb.sv
